//--- src/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data path and PC width
`define CORE_XLEN 32

// Bit counter over one execute phase
`define CORE_CNT_W 5

// Register index width
`define CORE_REG_W 5

`define CORE_RESET_PC 32'd0

`endif

//--- src/core_pkg.sv
`default_nettype none

`include "core_defs.svh"

package core_pkg;

   typedef logic [`CORE_REG_W-1:0] reg_addr_t;

   // Major opcodes handled by the core
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111
   } opcode_e;

   // Matches funct3[1:0] of XOR, OR and AND
   typedef enum logic [1:0] {
      BOOL_XOR = 2'b00,
      BOOL_OR  = 2'b10,
      BOOL_AND = 2'b11
   } bool_op_e;

   // Source of the rd bit stream
   typedef enum logic [1:0] {
      RD_ADD  = 2'b00,
      RD_BOOL = 2'b01,
      RD_IMM  = 2'b10
   } rd_sel_e;

endpackage

`default_nettype wire

//--- src/core_if.sv
`default_nettype none

// Bit count strobes of the execute phase
interface cnt_if;

   logic cnt_en;
   logic cnt0;
   logic cnt2;
   logic cnt_done;

   modport master (
      output cnt_en,
      output cnt0,
      output cnt2,
      output cnt_done
   );

   modport sink (
      input cnt_en,
      input cnt0,
      input cnt2,
      input cnt_done
   );

endinterface

// Decoded ALU controls
interface alu_ctrl_if import core_pkg::*;;

   logic     sub;
   bool_op_e bool_op;
   rd_sel_e  rd_sel;
   logic     op_b_imm;

   modport source (output sub, output bool_op, output rd_sel, output op_b_imm);

   modport sink (input sub, input bool_op, input rd_sel, input op_b_imm);

endinterface

`default_nettype wire

//--- src/core_state.sv
`default_nettype none

`include "core_defs.svh"

module core_state import core_pkg::*; (
   input  wire            clk,
   input  wire            i_rst_n,
   input  wire            i_ibus_ack,
   input  wire            i_rf_ready,
   input  wire            i_rd_write,
   input  wire reg_addr_t i_rd_addr,
   output logic           o_ibus_cyc,
   output logic           o_rf_rreq,
   output logic           o_wen0,
   cnt_if.master          cnt
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH,
      S_REQ,
      S_WAIT,
      S_EXEC
   } state_e;

   state_e                 state;
   state_e                 state_nxt;
   logic [`CORE_CNT_W-1:0] cnt_q;

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE: state_nxt = S_FETCH;
         S_FETCH: begin
            if (i_ibus_ack) begin
               state_nxt = S_REQ;
            end
         end
         // Ready may already arrive with the request
         S_REQ: state_nxt = i_rf_ready ? S_EXEC : S_WAIT;
         S_WAIT: begin
            if (i_rf_ready) begin
               state_nxt = S_EXEC;
            end
         end
         S_EXEC: begin
            if (cnt.cnt_done) begin
               state_nxt = S_FETCH;
            end
         end
         default: state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= S_IDLE;
         cnt_q <= '0;
      end else begin
         state <= state_nxt;
         if (cnt.cnt_en) begin
            cnt_q <= cnt_q + `CORE_CNT_W'd1;
         end
      end
   end

   assign o_ibus_cyc   = (state == S_FETCH);
   assign o_rf_rreq    = (state == S_REQ);
   assign cnt.cnt_en   = (state == S_EXEC);
   assign cnt.cnt0     = cnt.cnt_en & (cnt_q == '0);
   assign cnt.cnt2     = cnt.cnt_en & (cnt_q == `CORE_CNT_W'd2);
   assign cnt.cnt_done = cnt.cnt_en & (cnt_q == '1);

   // No write to x0
   assign o_wen0 = cnt.cnt_en & i_rd_write & (|i_rd_addr);

   // Counter must have wrapped back to bit 0 between instructions
   a_exec_starts_at_bit0 : assert property (@(posedge clk) disable iff (!i_rst_n)
      $rose(cnt.cnt_en) |-> cnt.cnt0);

   a_fetch_after_done : assert property (@(posedge clk) disable iff (!i_rst_n)
      cnt.cnt_done |=> o_ibus_cyc);

endmodule

`default_nettype wire

//--- src/core_decode.sv
`default_nettype none

`include "core_defs.svh"

module core_decode import core_pkg::*; (
   input  wire                  clk,
   input  wire                  i_ibus_ack,
   input  wire [`CORE_XLEN-1:0] i_instr,
   output logic                 o_rd_write,
   alu_ctrl_if.source           ctrl
);

   logic [2:0] funct3;
   logic       funct7_b5;
   logic       is_op;
   logic       is_op_imm;
   logic       is_lui;
   logic       funct3_ok;

   assign funct3    = i_instr[14:12];
   assign funct7_b5 = i_instr[30];
   assign is_op     = (i_instr[6:0] == OPC_OP);
   assign is_op_imm = (i_instr[6:0] == OPC_OP_IMM);
   assign is_lui    = (i_instr[6:0] == OPC_LUI);

   // ADD/SUB and the three boolean functions only
   always_comb begin
      case (funct3)
         3'b000, 3'b100, 3'b110, 3'b111: funct3_ok = 1'b1;
         default:                        funct3_ok = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         o_rd_write    <= is_lui | ((is_op | is_op_imm) & funct3_ok);
         // Immediate forms always add
         ctrl.sub      <= is_op & (funct3 == 3'b000) & funct7_b5;
         ctrl.op_b_imm <= !is_op;

         if (!funct3[1]) begin
            ctrl.bool_op <= BOOL_XOR;
         end else if (funct3[0]) begin
            ctrl.bool_op <= BOOL_AND;
         end else begin
            ctrl.bool_op <= BOOL_OR;
         end

         if (is_lui) begin
            ctrl.rd_sel <= RD_IMM;
         end else if (funct3 == 3'b000) begin
            ctrl.rd_sel <= RD_ADD;
         end else begin
            ctrl.rd_sel <= RD_BOOL;
         end
      end
   end

   // Fetched word must be fully known when it is acked
   a_instr_known : assert property (@(posedge clk)
      i_ibus_ack |-> !$isunknown(i_instr));

endmodule

`default_nettype wire

//--- src/core_immdec.sv
`default_nettype none

`include "core_defs.svh"

module core_immdec import core_pkg::*; (
   input  wire                  clk,
   input  wire                  i_ibus_ack,
   input  wire [`CORE_XLEN-1:0] i_instr,
   output reg_addr_t            o_rs1_addr,
   output reg_addr_t            o_rs2_addr,
   output reg_addr_t            o_rd_addr,
   output logic                 o_imm,
   cnt_if.sink                  cnt
);

   logic [`CORE_XLEN-1:0] imm_sr;
   logic                  is_lui;

   assign is_lui = (i_instr[6:0] == OPC_LUI);

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         o_rd_addr  <= i_instr[11:7];
         o_rs1_addr <= i_instr[19:15];
         o_rs2_addr <= i_instr[24:20];
         // U immediate has its low twelve bits clear
         if (is_lui) begin
            imm_sr <= {i_instr[31:12], 12'd0};
         end else begin
            imm_sr <= {{20{i_instr[31]}}, i_instr[31:20]};
         end
      end else if (cnt.cnt_en) begin
         // LSB first
         imm_sr <= {1'b0, imm_sr[`CORE_XLEN-1:1]};
      end
   end

   assign o_imm = imm_sr[0];

endmodule

`default_nettype wire

//--- src/core_alu.sv
`default_nettype none

module core_alu import core_pkg::*; (
   input  wire       clk,
   input  wire       i_rs1,
   input  wire       i_rs2,
   input  wire       i_imm,
   output logic      o_rd,
   cnt_if.sink       cnt,
   alu_ctrl_if.sink  ctrl
);

   logic op_b;
   logic op_b_add;
   logic carry_in;
   logic carry_out;
   logic carry_q;
   logic sum;
   logic bool_res;

   assign op_b     = ctrl.op_b_imm ? i_imm : i_rs2;
   // Two's complement subtract, invert B and carry in one
   assign op_b_add = op_b ^ ctrl.sub;
   assign carry_in = cnt.cnt0 ? ctrl.sub : carry_q;

   assign {carry_out, sum} = {1'b0, i_rs1} + {1'b0, op_b_add} + {1'b0, carry_in};

   always_ff @(posedge clk) begin
      if (cnt.cnt_en) begin
         carry_q <= carry_out;
      end
   end

   always_comb begin
      case (ctrl.bool_op)
         BOOL_OR:  bool_res = i_rs1 | op_b;
         BOOL_AND: bool_res = i_rs1 & op_b;
         default:  bool_res = i_rs1 ^ op_b;
      endcase
   end

   always_comb begin
      case (ctrl.rd_sel)
         RD_ADD:  o_rd = sum;
         RD_BOOL: o_rd = bool_res;
         RD_IMM:  o_rd = i_imm;
         default: o_rd = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- src/core_ctrl.sv
`default_nettype none

`include "core_defs.svh"

module core_ctrl import core_pkg::*; (
   input  wire                   clk,
   input  wire                   i_rst_n,
   output logic [`CORE_XLEN-1:0] o_ibus_adr,
   cnt_if.sink                   cnt
);

   logic [`CORE_XLEN-1:0] pc;
   logic                  carry_in;
   logic                  carry_out;
   logic                  carry_q;
   logic                  pc_sum;

   // Fresh carry chain each instruction
   assign carry_in = cnt.cnt0 ? 1'b0 : carry_q;

   // Adding one at bit 2 steps the PC by four
   assign {carry_out, pc_sum} = {1'b0, pc[0]} + {1'b0, cnt.cnt2} + {1'b0, carry_in};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc <= `CORE_RESET_PC;
      end else if (cnt.cnt_en) begin
         // Full rotation over 32 cycles
         pc <= {pc_sum, pc[`CORE_XLEN-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (cnt.cnt_en) begin
         carry_q <= carry_out;
      end
   end

   assign o_ibus_adr = pc;

endmodule

`default_nettype wire

//--- src/serial_core_top.sv
`default_nettype none

`include "core_defs.svh"

module serial_core_top import core_pkg::*; (
   input  wire                  clk,
   input  wire                  i_rst_n,
   // Instruction fetch bus
   input  wire [`CORE_XLEN-1:0] i_ibus_rdt,
   input  wire                  i_ibus_ack,
   output wire [`CORE_XLEN-1:0] o_ibus_adr,
   output wire                  o_ibus_cyc,
   // Register file
   output wire                  o_rf_rreq,
   input  wire                  i_rf_ready,
   output reg_addr_t            o_rreg0,
   output reg_addr_t            o_rreg1,
   input  wire                  i_rdata0,
   input  wire                  i_rdata1,
   output reg_addr_t            o_wreg0,
   output wire                  o_wen0,
   output wire                  o_wdata0
);

   wire rd_write;
   wire imm;

   cnt_if      cnt ();
   alu_ctrl_if alu_ctrl ();

   core_state state_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .i_rd_write (rd_write),
      .i_rd_addr  (o_wreg0),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .o_wen0     (o_wen0),
      .cnt        (cnt.master)
   );

   core_decode decode_i (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_instr    (i_ibus_rdt),
      .o_rd_write (rd_write),
      .ctrl       (alu_ctrl.source)
   );

   core_immdec immdec_i (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_instr    (i_ibus_rdt),
      .o_rs1_addr (o_rreg0),
      .o_rs2_addr (o_rreg1),
      .o_rd_addr  (o_wreg0),
      .o_imm      (imm),
      .cnt        (cnt.sink)
   );

   // rs1 and rs2 arrive on the two read ports
   core_alu alu_i (
      .clk   (clk),
      .i_rs1 (i_rdata0),
      .i_rs2 (i_rdata1),
      .i_imm (imm),
      .o_rd  (o_wdata0),
      .cnt   (cnt.sink),
      .ctrl  (alu_ctrl.sink)
   );

   core_ctrl ctrl_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_ibus_adr (o_ibus_adr),
      .cnt        (cnt.sink)
   );

endmodule

`default_nettype wire

//--- verification/tb_serial_core.sv
`default_nettype none

`include "core_defs.svh"

module tb_serial_core;

   localparam int CLK_PERIOD      = 40;
   localparam int SAMPLE_DLY      = CLK_PERIOD / 4;
   localparam int N_INSTR         = 400;
   localparam int WATCHDOG_CYCLES = N_INSTR * (32 + 12);

   localparam logic [6:0] OP_REG = 7'b0110011;
   localparam logic [6:0] OP_IMM = 7'b0010011;
   localparam logic [6:0] OP_LUI = 7'b0110111;

   logic                   clk;
   logic                   i_rst_n;
   logic [`CORE_XLEN-1:0]  i_ibus_rdt;
   logic                   i_ibus_ack;
   logic                   i_rf_ready;
   logic                   i_rdata0;
   logic                   i_rdata1;
   wire  [`CORE_XLEN-1:0]  o_ibus_adr;
   wire                    o_ibus_cyc;
   wire                    o_rf_rreq;
   wire  [`CORE_REG_W-1:0] o_rreg0;
   wire  [`CORE_REG_W-1:0] o_rreg1;
   wire  [`CORE_REG_W-1:0] o_wreg0;
   wire                    o_wen0;
   wire                    o_wdata0;

   integer      seed = 20601;
   int          mismatch_cnt;
   int          fail_cnt;
   logic [31:0] rf [32];
   logic [31:0] ref_regs [32];
   logic [31:0] exp_pc;

   serial_core_top dut_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .i_rf_ready (i_rf_ready),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_wreg0    (o_wreg0),
      .o_wen0     (o_wen0),
      .o_wdata0   (o_wdata0)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp) else begin
         $display("mismatch %s: got %h, expected %h", name, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      assert (cond === 1'b1) else begin
         $display("error: %s", what);
         fail_cnt++;
      end
   endtask

   function automatic logic is_supported(input logic [31:0] instr);
      logic f3_ok;
      f3_ok = instr[14:12] inside {3'b000, 3'b100, 3'b110, 3'b111};
      if (instr[6:0] == OP_LUI) begin
         return 1'b1;
      end
      return (instr[6:0] == OP_REG || instr[6:0] == OP_IMM) && f3_ok;
   endfunction

   // Expected rd value, computed from the instruction fields
   function automatic logic [31:0] ref_result(input logic [31:0] instr,
                                              input logic [31:0] a,
                                              input logic [31:0] r2);
      logic [31:0] b;
      logic [31:0] res;
      b = (instr[6:0] == OP_REG) ? r2 : {{20{instr[31]}}, instr[31:20]};
      case (instr[14:12])
         3'b100:  res = a ^ b;
         3'b110:  res = a | b;
         3'b111:  res = a & b;
         default: res = (instr[6:0] == OP_REG && instr[30]) ? a - b : a + b;
      endcase
      if (instr[6:0] == OP_LUI) begin
         res = {instr[31:12], 12'd0};
      end
      return res;
   endfunction

   function automatic logic [31:0] gen_instr();
      logic [31:0] fields;
      logic [31:0] sel;
      logic [2:0]  f3;
      logic [2:0]  bad_f3;
      logic [4:0]  rd;
      logic [6:0]  f7;
      logic [6:0]  opc;
      fields = rand_word();
      sel    = rand_word();
      case (sel[5:4])
         2'd0:    f3 = 3'b000;
         2'd1:    f3 = 3'b100;
         2'd2:    f3 = 3'b110;
         default: f3 = 3'b111;
      endcase
      case (sel[11:10])
         2'd0:    bad_f3 = 3'b001;
         2'd1:    bad_f3 = 3'b010;
         2'd2:    bad_f3 = 3'b011;
         default: bad_f3 = 3'b101;
      endcase
      // x0 as destination now and then
      rd  = (sel[8:6] == 3'd0) ? 5'd0 : fields[11:7];
      f7  = (f3 == 3'b000 && sel[9]) ? 7'h20 : 7'h00;
      opc = sel[22:16];
      if (opc == OP_REG || opc == OP_IMM || opc == OP_LUI) begin
         opc[0] = 1'b0;
      end
      if (sel[3:0] < 4'd6) begin
         return {f7, fields[24:15], f3, rd, OP_REG};
      end else if (sel[3:0] < 4'd11) begin
         return {fields[31:15], f3, rd, OP_IMM};
      end else if (sel[3:0] < 4'd13) begin
         return {fields[31:12], rd, OP_LUI};
      end else if (sel[3:0] == 4'd13) begin
         return {fields[31:15], bad_f3, rd, sel[12] ? OP_REG : OP_IMM};
      end
      return {fields[31:12], rd, opc};
   endfunction

   // Starts on a falling edge where the fetch should be pending
   task automatic run_instr(input logic [31:0] instr);
      int          delay;
      int          wen_cnt;
      logic [31:0] word;
      logic [31:0] expected;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [4:0]  rd;
      logic        writes;
      rs1      = instr[19:15];
      rs2      = instr[24:20];
      rd       = instr[11:7];
      writes   = is_supported(instr) && (rd != 5'd0);
      expected = ref_result(instr, ref_regs[rs1], ref_regs[rs2]);
      wen_cnt  = 0;
      word     = '0;

      expect_true(o_ibus_cyc, "o_ibus_cyc not raised for the next fetch");
      while (!o_ibus_cyc) begin
         @(negedge clk);
      end
      compare_word("o_ibus_adr", o_ibus_adr, exp_pc);
      delay = int'(rand_word() % 32'd4);
      repeat (delay) begin
         @(negedge clk);
         expect_true(o_ibus_cyc, "o_ibus_cyc dropped before the ack");
         compare_word("o_ibus_adr", o_ibus_adr, exp_pc);
      end
      i_ibus_ack = 1'b1;
      i_ibus_rdt = instr;
      @(negedge clk);
      i_ibus_ack = 1'b0;
      i_ibus_rdt = rand_word();

      expect_true(!o_ibus_cyc, "o_ibus_cyc still high after the ack");
      expect_true(o_rf_rreq, "o_rf_rreq missing in the cycle after the ack");
      compare_word("o_rreg0", 32'(o_rreg0), 32'(rs1));
      compare_word("o_rreg1", 32'(o_rreg1), 32'(rs2));
      delay = int'(rand_word() % 32'd5);
      repeat (delay) begin
         @(negedge clk);
         expect_true(!o_rf_rreq, "o_rf_rreq held for more than one cycle");
         expect_true(!o_wen0, "o_wen0 high while waiting for ready");
      end
      i_rf_ready = 1'b1;
      @(negedge clk);
      i_rf_ready = 1'b0;

      // One bit per cycle, LSB first
      for (int k = 0; k < 32; k++) begin
         i_rdata0 = rf[rs1][k];
         i_rdata1 = rf[rs2][k];
         #(SAMPLE_DLY);
         word[k] = o_wdata0;
         if (o_wen0) begin
            wen_cnt++;
            compare_word("o_wreg0", 32'(o_wreg0), 32'(rd));
            if (o_wreg0 != 5'd0) begin
               rf[o_wreg0][k] = o_wdata0;
            end
         end
         @(negedge clk);
      end
      i_rdata0 = 1'b0;
      i_rdata1 = 1'b0;

      if (is_supported(instr)) begin
         compare_word("o_wdata0 word", word, expected);
      end
      expect_true(wen_cnt == (writes ? 32 : 0),
                  $sformatf("saw %0d o_wen0 cycles for instruction %h", wen_cnt, instr));
      if (writes) begin
         ref_regs[rd] = expected;
      end
      for (int i = 0; i < 32; i++) begin
         compare_word($sformatf("x%0d", i), rf[i], ref_regs[i]);
      end
      exp_pc = exp_pc + 32'd4;
   endtask

   initial begin
      mismatch_cnt = 0;
      fail_cnt     = 0;
      clk          = 1'b0;
      i_rst_n      = 1'b0;
      i_ibus_rdt   = '0;
      i_ibus_ack   = 1'b0;
      i_rf_ready   = 1'b0;
      i_rdata0     = 1'b0;
      i_rdata1     = 1'b0;
      exp_pc       = `CORE_RESET_PC;
      for (int i = 0; i < 32; i++) begin
         rf[i]       = (i == 0) ? 32'd0 : rand_word();
         ref_regs[i] = rf[i];
      end

      repeat (3) begin
         @(negedge clk);
         expect_true(!o_ibus_cyc && !o_rf_rreq && !o_wen0,
                     "bus request or write enable active during reset");
      end
      i_rst_n = 1'b1;
      @(negedge clk);

      for (int n = 0; n < N_INSTR; n++) begin
         run_instr(gen_instr());
      end

      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt + fail_cnt == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("error: watchdog expired before %0d instructions completed", N_INSTR);
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt + 1);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- serial_core.f
+incdir+src
src/core_pkg.sv
src/core_if.sv
src/core_state.sv
src/core_decode.sv
src/core_immdec.sv
src/core_alu.sv
src/core_ctrl.sv
src/serial_core_top.sv
verification/tb_serial_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_serial_core \
   --Mdir obj_dir \
   -f serial_core.f

out=$(./obj_dir/Vtb_serial_core)
echo "$out"

if echo "$out" | grep -q "^TEST OK$"; then
   exit 0
fi
exit 1
